// File: bus0_cfg.svh
// Bus host configuration with register reload values, LFSR seed and trigger bytes
`ifndef BUS0_CFG_SVH
`define BUS0_CFG_SVH

// Register reload values
`define BUS0_REG0_INIT 32'h89AB_CDEF
`define BUS0_REG1_INIT 32'h0984_4DFE
`define BUS0_REG2_INIT 32'h89AB_CDEF
`define BUS0_REG3_INIT 32'h856E_E81F

// LFSR seed with low byte D5 and bits 127 to 124 clear.
// First advance gives AA in the low byte (feedback 0^1^0^1 = 0).
// Second advance gives 55 (feedback 0^0^1^0 = 1), so the
// trigger fires on the second request after reset.
`define BUS0_LFSR_INIT 128'h0123_4567_89AB_CDEF_0123_4567_89AB_CDD5

// Trigger sequence seen on the LFSR low byte
`define BUS0_TRIG_SEQ1 8'hAA
`define BUS0_TRIG_SEQ2 8'h55

`endif

// File: bus0_pkg.sv
// Bus host package with shared width types and the transfer state encoding
package bus0_pkg;

    // Data word on the bus and in the slave registers
    typedef logic [31:0] bus_word_t;

    // Register select
    typedef logic [1:0] reg_idx_t;

    // Byte watched by the trigger
    typedef logic [7:0] trig_byte_t;

    // Full LFSR state
    typedef logic [127:0] lfsr_state_t;

    // Five-step transfer sequence
    typedef enum logic [2:0] {
        host_idle,
        host_arb,
        host_xfer,
        host_out,
        host_done
    } host_state_t;

endpackage

// File: reg_bank_if.sv
// Host to register bank link carrying select, swap data and reload
`timescale 1ns/1ps

interface reg_bank_if import bus0_pkg::*; ();

    reg_idx_t  sel;    // Register being accessed
    bus_word_t wdata;  // New register content
    logic      swap;   // One-cycle swap strobe
    bus_word_t rdata;  // Content from before the swap
    logic      reload; // Restore every register to its init value

    modport host (
        output sel,
        output wdata,
        output swap,
        output reload,
        input  rdata
    );

    modport bank (
        input  sel,
        input  wdata,
        input  swap,
        input  reload,
        output rdata
    );

endinterface

// File: pattern_lfsr.sv
// 128-bit pattern LFSR stepping on request cycles and exposing its low byte
`timescale 1ns/1ps
`include "bus0_cfg.svh"

module pattern_lfsr import bus0_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    output trig_byte_t lfsr_byte
);

    lfsr_state_t lfsr_q;
    logic        feedback;

    // Taps at 127, 6, 1 and 0
    assign feedback = lfsr_q[127] ^ lfsr_q[6] ^ lfsr_q[1] ^ lfsr_q[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= `BUS0_LFSR_INIT;
        end else if (advance) begin
            lfsr_q <= {lfsr_q[126:0], feedback}; // Shift left with feedback into bit 0
        end
    end

    assign lfsr_byte = lfsr_q[7:0];

endmodule

// File: trigger_detector.sv
// Two-byte sequence detector that pulses force_reset on SEQ1 then SEQ2
`timescale 1ns/1ps
`include "bus0_cfg.svh"

module trigger_detector import bus0_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  trig_byte_t lfsr_byte,
    output logic       force_reset
);

    logic armed_q;
    logic fire_q;
    logic hit_seq1;
    logic hit_seq2;

    assign hit_seq1 = (lfsr_byte == `BUS0_TRIG_SEQ1);
    assign hit_seq2 = (lfsr_byte == `BUS0_TRIG_SEQ2);

    // Armed while the byte sits on SEQ1
    // Any other byte drops it again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= hit_seq1;
        end
    end

    // SEQ2 right after SEQ1 fires for one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fire_q <= 1'b0;
        end else begin
            fire_q <= armed_q && hit_seq2;
        end
    end

    assign force_reset = fire_q;

    // Firing needs SEQ1 the cycle before, so two fires cannot be adjacent
    a_fire_single: assert property (
        @(posedge clk) disable iff (rst)
        force_reset |=> !force_reset
    ) else $error("force_reset held for more than one cycle");

endmodule

// File: slave_reg_bank.sv
// Four 32-bit slave registers with swap access and reload to init values
`timescale 1ns/1ps
`include "bus0_cfg.svh"

module slave_reg_bank import bus0_pkg::*; (
    input logic        clk,
    input logic        rst,
    reg_bank_if.bank   bank
);

    localparam int NUM_REGS = 4;

    localparam bus_word_t INIT_VAL [NUM_REGS] = '{
        `BUS0_REG0_INIT,
        `BUS0_REG1_INIT,
        `BUS0_REG2_INIT,
        `BUS0_REG3_INIT
    };

    bus_word_t regs_q [NUM_REGS];

    // Registers restore on reset and on reload
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= INIT_VAL[i];
            end
        end else if (bank.reload) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= INIT_VAL[i];
            end
        end else if (bank.swap) begin
            regs_q[bank.sel] <= bank.wdata;
        end
    end

    // Old content leaves at the same edge the new one lands
    always_ff @(posedge clk) begin
        if (bank.swap) begin
            bank.rdata <= regs_q[bank.sel];
        end
    end

    // Host must abort a swap when the trigger fires
    a_no_swap_reload: assert property (
        @(posedge clk) disable iff (rst)
        !(bank.swap && bank.reload)
    ) else $error("swap and reload asserted together");

endmodule

// File: bus0_host.sv
// Bus host FSM that sequences the register swap and drives slave_data and bus_ack
`timescale 1ns/1ps

module bus0_host import bus0_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bus_word_t master_data,
    input  logic      master_req,
    input  reg_idx_t  reg_sel,
    input  logic      force_reset,
    reg_bank_if.host  host,
    output bus_word_t slave_data,
    output logic      bus_ack
);

    host_state_t state_q;
    host_state_t state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        if (force_reset) begin
            state_d = host_idle; // Abort whatever is in flight
        end else begin
            case (state_q)
                host_idle: begin
                    if (master_req) begin
                        state_d = host_arb;
                    end
                end
                host_arb:  state_d = host_xfer;
                host_xfer: state_d = host_out;
                host_out:  state_d = host_done;
                host_done: state_d = host_idle;
                default:   state_d = host_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= host_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Requester keeps reg_sel and master_data steady until ack
    assign host.sel    = reg_sel;
    assign host.wdata  = master_data;
    assign host.swap   = (state_q == host_xfer) && !force_reset;
    assign host.reload = force_reset; // Relay trigger to the bank

    // Response path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slave_data <= '0;
            bus_ack    <= 1'b0;
        end else if (force_reset) begin
            slave_data <= '0;
            bus_ack    <= 1'b0;
        end else begin
            bus_ack <= (state_q == host_out);
            if (state_q == host_out) begin
                slave_data <= host.rdata; // Value from before the swap
            end
        end
    end

    // Ack is always a single-cycle pulse
    a_ack_pulse: assert property (
        @(posedge clk) disable iff (rst)
        bus_ack |=> !bus_ack
    ) else $error("bus_ack held for more than one cycle");

    // State register never leaves the enum
    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state_q inside {host_idle, host_arb, host_xfer, host_out, host_done}
    ) else $error("illegal host state");

    // Ack follows a request by exactly four edges unless aborted
    a_req_to_ack: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == host_idle && master_req && !force_reset)
            ##1 (!force_reset [*3]) |=> bus_ack
    ) else $error("bus_ack missing four cycles after request");

endmodule

// File: trojan2_bus0_top.sv
// Bus host top level joining the host FSM, register bank, LFSR and trigger
`timescale 1ns/1ps
`include "bus0_cfg.svh"

module trojan2_bus0_top import bus0_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  bus_word_t master_data,
    input  logic      master_req,
    input  reg_idx_t  reg_sel,
    output bus_word_t slave_data,
    output logic      bus_ack
);

    trig_byte_t lfsr_byte;
    logic       force_reset;

    reg_bank_if bank_bus ();

    // Pattern source steps once per request cycle
    pattern_lfsr u_lfsr (
        .clk       (clk),
        .rst       (rst),
        .advance   (master_req),
        .lfsr_byte (lfsr_byte)
    );

    trigger_detector u_trigger (
        .clk         (clk),
        .rst         (rst),
        .lfsr_byte   (lfsr_byte),
        .force_reset (force_reset)
    );

    slave_reg_bank u_bank (
        .clk  (clk),
        .rst  (rst),
        .bank (bank_bus.bank)
    );

    bus0_host u_host (
        .clk         (clk),
        .rst         (rst),
        .master_data (master_data),
        .master_req  (master_req),
        .reg_sel     (reg_sel),
        .force_reset (force_reset),
        .host        (bank_bus.host),
        .slave_data  (slave_data),
        .bus_ack     (bus_ack)
    );

endmodule

// File: tb_trojan2_bus0.sv
// Self-checking testbench for the bus host with register swap and LFSR trigger
`timescale 1ns/1ps
`include "bus0_cfg.svh"

module tb_trojan2_bus0 import bus0_pkg::*; ();

    localparam int ACK_TIMEOUT  = 20;
    localparam int ABORT_WINDOW = 8;
    localparam int ACK_EDGES    = 3;   // Ack registered at the third edge after the request edge
    localparam int RANDOM_XFERS = 200;

    logic      clk;
    logic      rst;
    bus_word_t master_data;
    logic      master_req;
    reg_idx_t  reg_sel;
    bus_word_t slave_data;
    logic      bus_ack;

    lfsr_state_t lfsr_m;       // Model of the pattern LFSR
    bus_word_t   shadow [4];   // Model of the register bank
    logic [31:0] rng_state;
    logic        started;      // First request issued
    logic        ack_allowed;  // A transfer that should end in an ack is in flight
    int          ack_count;
    int          abort_count;

    trojan2_bus0_top dut (
        .clk         (clk),
        .rst         (rst),
        .master_data (master_data),
        .master_req  (master_req),
        .reg_sel     (reg_sel),
        .slave_data  (slave_data),
        .bus_ack     (bus_ack)
    );

    always #4 clk = ~clk;

    function automatic bus_word_t init_word(input reg_idx_t idx);
        case (idx)
            2'd0:    return `BUS0_REG0_INIT;
            2'd1:    return `BUS0_REG1_INIT;
            2'd2:    return `BUS0_REG2_INIT;
            default: return `BUS0_REG3_INIT;
        endcase
    endfunction

    // Taps 127, 6, 1 and 0 feed bit 0 on a left shift
    function automatic lfsr_state_t lfsr_next(input lfsr_state_t s);
        return {s[126:0], s[127] ^ s[6] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        assert (got === exp) else
            abort_run($sformatf("error at %0t: %s got 0x%h expected 0x%h",
                                $time, name, got, exp));
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        assert (got == exp) else
            abort_run($sformatf("error at %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
    endtask

    task automatic reset_shadow();
        for (int i = 0; i < 4; i++) begin
            shadow[i] = init_word(reg_idx_t'(i));
        end
    endtask

    // One request, called 1 ns after a rising edge and returning at the same phase
    task automatic do_transfer(input reg_idx_t sel, input bus_word_t data,
                               output logic aborted, output bus_word_t got);
        trig_byte_t old_byte;
        bus_word_t  expect_word;
        int         edges;
        logic       seen;
        time        req_time;

        old_byte    = lfsr_m[7:0];
        lfsr_m      = lfsr_next(lfsr_m);
        aborted     = (old_byte == `BUS0_TRIG_SEQ1) && (lfsr_m[7:0] == `BUS0_TRIG_SEQ2);
        expect_word = shadow[sel];
        got         = '0;
        ack_allowed = !aborted;
        started     = 1'b1;
        master_req  = 1'b1;
        reg_sel     = sel;
        master_data = data;
        @(posedge clk);
        req_time = $time;
        #1;
        master_req = 1'b0;
        edges      = 0;
        seen       = 1'b0;
        if (aborted) begin
            // Swap is dropped and the bank reloads
            while (edges < ABORT_WINDOW) begin
                @(posedge clk);
                #1;
                edges++;
                if (bus_ack) begin
                    abort_run($sformatf("bus_ack came after the trigger fired at %0t",
                                        req_time));
                end
            end
            check_word("slave_data after abort", slave_data, '0);
            reset_shadow();
            abort_count++;
        end else begin
            while (!seen && edges < ACK_TIMEOUT) begin
                @(posedge clk);
                #1;
                edges++;
                seen = bus_ack;
            end
            if (!seen) begin
                abort_run($sformatf("no bus_ack within %0d cycles of the request at %0t",
                                    ACK_TIMEOUT, req_time));
            end
            check_int("bus_ack latency", edges, ACK_EDGES);
            check_word("slave_data", slave_data, expect_word);
            got = slave_data;
            @(posedge clk);
            #1;
            check_int("bus_ack after pulse", int'(bus_ack), 0);
            ack_allowed = 1'b0;
            shadow[sel] = data; // Register now holds the written word
            ack_count++;
        end
    endtask

    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        bus_ack |=> !bus_ack
    ) else abort_run("bus_ack stayed high for more than one cycle");

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (rst)
        !started |-> (!bus_ack && slave_data == '0)
    ) else abort_run("outputs not idle between reset and the first request");

    a_ack_expected: assert property (
        @(posedge clk) disable iff (rst)
        bus_ack |-> ack_allowed
    ) else abort_run("bus_ack raised without a pending transfer");

    initial begin
        logic        aborted;
        bus_word_t   got;
        logic [31:0] r;
        logic [31:0] d;

        clk         = 1'b0;
        rst         = 1'b1;
        master_req  = 1'b0;
        master_data = '0;
        reg_sel     = '0;
        started     = 1'b0;
        ack_allowed = 1'b0;
        ack_count   = 0;
        abort_count = 0;
        rng_state   = 32'h64e27b96;
        lfsr_m      = `BUS0_LFSR_INIT;
        reset_shadow();

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle outputs before any request
        repeat (6) begin
            @(posedge clk);
            #1;
            check_int("bus_ack", int'(bus_ack), 0);
            check_word("slave_data", slave_data, '0);
        end

        // Low byte goes D5 to AA, then AA to 55 which fires
        next_rand(d);
        do_transfer(2'd0, d, aborted, got);
        check_int("trigger on first request", int'(aborted), 0);
        check_word("slave_data on first request", got, `BUS0_REG0_INIT);
        next_rand(d);
        do_transfer(2'd1, d, aborted, got);
        check_int("trigger on second request", int'(aborted), 1);

        // First access after the reload sees the init values
        for (int i = 0; i < 4; i++) begin
            next_rand(d);
            do_transfer(reg_idx_t'(i), d, aborted, got);
            if (!aborted) begin
                check_word("slave_data after reload", got, init_word(reg_idx_t'(i)));
            end
        end

        for (int n = 0; n < RANDOM_XFERS; n++) begin
            next_rand(r);
            next_rand(d);
            do_transfer(r[5:4], d, aborted, got);
        end

        $display("transfers acked %0d, aborted %0d", ack_count, abort_count);
        if (abort_count < 1) begin
            abort_run("the trigger never fired");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: src.f
+incdir+.
bus0_pkg.sv
reg_bank_if.sv
pattern_lfsr.sv
trigger_detector.sv
slave_reg_bank.sv
bus0_host.sv
trojan2_bus0_top.sv
tb_trojan2_bus0.sv

// File: run.sh
#!/bin/sh
# Compile the bus host testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_trojan2_bus0 \
    -f src.f \
    -Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
